// ==== bus_events_if.sv ====
`default_nettype none

interface bus_events_if;

    // One-cycle strobes from the line monitor
    logic sck_rise;
    logic sck_fall;
    logic start;
    logic stop;
    // Synchronized SDA level
    logic sda_bit;

    modport monitor (
        output sck_rise, sck_fall, start, stop, sda_bit
    );

    modport engine (
        input sck_rise, sck_fall, start, stop, sda_bit
    );

endinterface

`default_nettype wire

// ==== eeprom_array.sv ====
`default_nettype none

module eeprom_array (
    input  logic     scl,
    input  logic     rst_n,
    mem_if.store     mem
);

    import eeprom_pkg::*;

    byte_t mem_arr [mem_depth];

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Device starts out blank
            for (int i = 0; i < mem_depth; i++)
            begin
                mem_arr[i] <= '0;
            end
            mem.rd_data <= '0;
        end
        else
        begin
            if (mem.wr_en)
            begin
                mem_arr[mem.addr] <= mem.wr_data;
            end
            mem.rd_data <= mem_arr[mem.addr];
        end
    end

endmodule

`default_nettype wire

// ==== eeprom_pkg.sv ====
`default_nettype none

package eeprom_pkg;

    // Fixed device-type nibble of the control byte
    localparam logic [3:0] dev_type = 4'b1010;

    // Page bits sit in control byte bits 3..1
    localparam int page_width = 3;
    localparam int mem_addr_width = page_width + 8;
    localparam int mem_depth = 2 ** mem_addr_width;

    typedef logic [mem_addr_width-1:0] mem_addr_t;
    typedef logic [7:0] byte_t;

    typedef enum logic [3:0] {
        idle,
        get_ctrl,
        ack_ctrl,
        get_addr,
        ack_addr,
        get_data,
        ack_data,
        send_data,
        wait_master_ack
    } proto_state_e;

endpackage

`default_nettype wire

// ==== eeprom_protocol.sv ====
`default_nettype none

module eeprom_protocol (
    input  logic         scl,
    input  logic         rst_n,
    bus_events_if.engine events,
    mem_if.host          mem,
    output logic         sda_oe
);

    import eeprom_pkg::*;

    proto_state_e          state;
    logic [2:0]            bit_cnt;
    byte_t                 shift_reg;
    byte_t                 byte_in;
    byte_t                 addr_byte;
    byte_t                 data_byte;
    logic [page_width-1:0] page;
    logic                  rd_flag;
    logic                  ack_on;
    logic                  receiving;
    logic                  byte_done;
    logic                  ctrl_match;

    // Byte as it looks once the current bit is shifted in
    assign byte_in    = {shift_reg[6:0], events.sda_bit};
    assign ctrl_match = (byte_in[7:4] == dev_type);

    assign receiving = (state == get_ctrl) || (state == get_addr) || (state == get_data);
    assign byte_done = receiving && events.sck_rise && (bit_cnt == 3'd7);

    assign mem.addr    = {page, addr_byte};
    assign mem.wr_data = data_byte;
    // Commit on the falling edge that closes the data acknowledge
    assign mem.wr_en   = (state == ack_data) && ack_on && events.sck_fall;

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= idle;
            bit_cnt   <= 3'd0;
            shift_reg <= '0;
            addr_byte <= '0;
            data_byte <= '0;
            page      <= '0;
            rd_flag   <= 1'b0;
            ack_on    <= 1'b0;
            sda_oe    <= 1'b0;
        end
        else if (events.stop)
        begin
            state  <= idle;
            ack_on <= 1'b0;
            sda_oe <= 1'b0;
        end
        else if (events.start)
        begin
            // Also covers the repeated start of a random read
            state   <= get_ctrl;
            bit_cnt <= 3'd0;
            ack_on  <= 1'b0;
            sda_oe  <= 1'b0;
        end
        else
        begin
            if (receiving && events.sck_rise)
            begin
                shift_reg <= byte_in;
                bit_cnt   <= bit_cnt + 3'd1;
            end

            case (state)
                get_ctrl:
                begin
                    if (byte_done)
                    begin
                        if (ctrl_match)
                        begin
                            page    <= byte_in[page_width:1];
                            rd_flag <= byte_in[0];
                            state   <= ack_ctrl;
                        end
                        else
                        begin
                            // Not addressed, stay off the bus
                            state <= idle;
                        end
                    end
                end

                get_addr:
                begin
                    if (byte_done)
                    begin
                        addr_byte <= byte_in;
                        state     <= ack_addr;
                    end
                end

                get_data:
                begin
                    if (byte_done)
                    begin
                        data_byte <= byte_in;
                        state     <= ack_data;
                    end
                end

                ack_ctrl, ack_addr, ack_data:
                begin
                    if (events.sck_fall)
                    begin
                        if (!ack_on)
                        begin
                            ack_on <= 1'b1;
                            sda_oe <= 1'b1;
                        end
                        else
                        begin
                            ack_on  <= 1'b0;
                            sda_oe  <= 1'b0;
                            bit_cnt <= 3'd0;
                            if (state == ack_ctrl && rd_flag)
                            begin
                                // First read bit goes out on the same edge
                                shift_reg <= mem.rd_data;
                                sda_oe    <= ~mem.rd_data[7];
                                state     <= send_data;
                            end
                            else if (state == ack_ctrl)
                                state <= get_addr;
                            else if (state == ack_addr)
                                state <= get_data;
                            else
                                state <= idle;
                        end
                    end
                end

                send_data:
                begin
                    if (events.sck_fall)
                    begin
                        if (bit_cnt == 3'd7)
                        begin
                            // Free the line for the master's acknowledge
                            sda_oe <= 1'b0;
                            state  <= wait_master_ack;
                        end
                        else
                        begin
                            sda_oe    <= ~shift_reg[6];
                            shift_reg <= {shift_reg[6:0], 1'b0};
                            bit_cnt   <= bit_cnt + 3'd1;
                        end
                    end
                end

                // Master ack is not acted on, only stop or start leaves
                wait_master_ack:
                begin
                    sda_oe <= 1'b0;
                end

                idle:
                begin
                    sda_oe <= 1'b0;
                end

                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== eeprom_top.sv ====
`default_nettype none

module eeprom_top #(
    parameter int sync_stages = 2
) (
    input  logic scl,
    input  logic rst_n,
    input  logic sck,
    input  logic sda_in,
    output logic sda_oe
);

    bus_events_if events_bus ();
    mem_if        mem_bus ();

    // Synchronizer and bus condition decode
    i2c_line_monitor #(
        .sync_stages (sync_stages)
    ) i_line_monitor (
        .scl    (scl),
        .rst_n  (rst_n),
        .sck    (sck),
        .sda_in (sda_in),
        .events (events_bus.monitor)
    );

    eeprom_protocol i_protocol (
        .scl    (scl),
        .rst_n  (rst_n),
        .events (events_bus.engine),
        .mem    (mem_bus.host),
        .sda_oe (sda_oe)
    );

    eeprom_array i_array (
        .scl   (scl),
        .rst_n (rst_n),
        .mem   (mem_bus.store)
    );

endmodule

`default_nettype wire

// ==== i2c_line_monitor.sv ====
`default_nettype none

module i2c_line_monitor #(
    parameter int sync_stages = 2
) (
    input  logic          scl,
    input  logic          rst_n,
    input  logic          sck,
    input  logic          sda_in,
    bus_events_if.monitor events
);

    logic [sync_stages-1:0] sck_sync;
    logic [sync_stages-1:0] sda_sync;
    logic                   sck_cur;
    logic                   sda_cur;
    logic                   sck_prev;
    logic                   sda_prev;

    assign sck_cur = sck_sync[sync_stages-1];
    assign sda_cur = sda_sync[sync_stages-1];

    always_ff @(posedge scl or negedge rst_n)
    begin
        if (!rst_n)
        begin
            // Idle bus reads high on both lines
            sck_sync        <= '1;
            sda_sync        <= '1;
            sck_prev        <= 1'b1;
            sda_prev        <= 1'b1;
            events.sck_rise <= 1'b0;
            events.sck_fall <= 1'b0;
            events.start    <= 1'b0;
            events.stop     <= 1'b0;
            events.sda_bit  <= 1'b1;
        end
        else
        begin
            sck_sync <= {sck_sync[sync_stages-2:0], sck};
            sda_sync <= {sda_sync[sync_stages-2:0], sda_in};
            sck_prev <= sck_cur;
            sda_prev <= sda_cur;

            events.sck_rise <= sck_cur & ~sck_prev;
            events.sck_fall <= ~sck_cur & sck_prev;
            // SDA edges count only while SCK holds high in both samples
            events.start    <= sck_cur & sck_prev & ~sda_cur & sda_prev;
            events.stop     <= sck_cur & sck_prev & sda_cur & ~sda_prev;
            events.sda_bit  <= sda_cur;
        end
    end

endmodule

`default_nettype wire

// ==== mem_if.sv ====
`default_nettype none

interface mem_if;

    import eeprom_pkg::*;

    mem_addr_t addr;
    logic      wr_en;
    byte_t     wr_data;
    // Registered, one cycle behind addr
    byte_t     rd_data;

    modport host (
        output addr, wr_en, wr_data,
        input  rd_data
    );

    modport store (
        input  addr, wr_en, wr_data,
        output rd_data
    );

endinterface

`default_nettype wire

// ==== project.f ====
eeprom_pkg.sv
bus_events_if.sv
mem_if.sv
i2c_line_monitor.sv
eeprom_protocol.sv
eeprom_array.sv
eeprom_top.sv
tb_eeprom_top.sv

// ==== tb_eeprom_top.sv ====
`default_nettype none

module tb_eeprom_top;

    timeunit 1ns;
    timeprecision 1ns;

    import eeprom_pkg::*;

    localparam int sync_stages = 2;
    localparam int reset_cycles = 16;
    localparam int n_entries = 39;
    // Longest entry is a random read of about 80 bus half-periods of 8 cycles
    localparam int timeout_limit = n_entries * 100 * 8 + reset_cycles;

    typedef enum logic [1:0] {op_write, op_read, op_abort} tb_op_e;

    logic scl;
    logic rst_n;
    logic sck;
    logic sda_m;
    logic sda_oe;
    wire  sda_bus;

    tb_op_e     op_tab [n_entries];
    logic [3:0] dev_tab [n_entries];
    logic [2:0] page_tab [n_entries];
    byte_t      addr_tab [n_entries];
    byte_t      data_tab [n_entries];
    logic       ack_tab [n_entries];
    string      name_tab [n_entries];
    int         n_used;

    byte_t       ref_mem [mem_depth];
    logic [2:0]  rnd_page [12];
    byte_t       rnd_addr [12];
    byte_t       rnd_data [12];
    logic [31:0] rnd_word;
    integer      seed;
    int          errors;
    int          checks;
    int          cycle_count;

    // Open-drain line is low if either side pulls
    assign sda_bus = sda_m & ~sda_oe;

    eeprom_top #(
        .sync_stages (sync_stages)
    ) i_eeprom_top (
        .scl    (scl),
        .rst_n  (rst_n),
        .sck    (sck),
        .sda_in (sda_bus),
        .sda_oe (sda_oe)
    );

    initial
    begin
        scl = 1'b0;
        forever #10 scl = ~scl;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge scl);
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // One bus clock with sck low on entry and on exit
    task automatic clock_bit(input logic bit_out, output logic bit_seen);
        wait_cycles(2);
        sda_m = bit_out;
        wait_cycles(6);
        sck = 1'b1;
        wait_cycles(4);
        bit_seen = sda_bus;
        wait_cycles(4);
        sck = 1'b0;
    endtask

    task automatic send_start();
        wait_cycles(2);
        sda_m = 1'b1;
        wait_cycles(6);
        sck = 1'b1;
        wait_cycles(8);
        sda_m = 1'b0;
        wait_cycles(8);
        sck = 1'b0;
    endtask

    task automatic send_stop();
        wait_cycles(2);
        sda_m = 1'b0;
        wait_cycles(6);
        sck = 1'b1;
        wait_cycles(8);
        sda_m = 1'b1;
        wait_cycles(8);
    endtask

    task automatic send_byte(input byte_t b, output logic ack);
        logic seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(b[i], seen);
        end
        clock_bit(1'b1, seen);
        ack = ~seen;
    endtask

    // Master answers with a NACK after the byte
    task automatic recv_byte(output byte_t b);
        logic seen;
        for (int i = 7; i >= 0; i--)
        begin
            clock_bit(1'b1, seen);
            b[i] = seen;
        end
        clock_bit(1'b1, seen);
    endtask

    task automatic add_entry(input tb_op_e op, input logic [3:0] dev, input logic [2:0] page,
                             input byte_t addr, input byte_t data, input logic ack,
                             input string name);
        op_tab[n_used]   = op;
        dev_tab[n_used]  = dev;
        page_tab[n_used] = page;
        addr_tab[n_used] = addr;
        data_tab[n_used] = data;
        ack_tab[n_used]  = ack;
        name_tab[n_used] = name;
        n_used++;
    endtask

    task automatic run_entry(input int i);
        logic      ack;
        byte_t     got;
        mem_addr_t loc;
        loc = {page_tab[i], addr_tab[i]};
        send_start();
        send_byte({dev_tab[i], page_tab[i], 1'b0}, ack);
        check_value({name_tab[i], " ctrl ack"}, {7'd0, ack_tab[i]}, {7'd0, ack});
        send_byte(addr_tab[i], ack);
        check_value({name_tab[i], " addr ack"}, {7'd0, ack_tab[i]}, {7'd0, ack});
        if (op_tab[i] == op_write)
        begin
            send_byte(data_tab[i], ack);
            check_value({name_tab[i], " data ack"}, {7'd0, ack_tab[i]}, {7'd0, ack});
            if (ack_tab[i])
                ref_mem[loc] = data_tab[i];
        end
        else if (op_tab[i] == op_read)
        begin
            send_start();
            send_byte({dev_tab[i], page_tab[i], 1'b1}, ack);
            check_value({name_tab[i], " read ctrl ack"}, {7'd0, ack_tab[i]}, {7'd0, ack});
            recv_byte(got);
            check_value(name_tab[i], ref_mem[loc], got);
        end
        send_stop();
    endtask

    initial
    begin
        cycle_count = 0;
        while (cycle_count < timeout_limit)
        begin
            @(posedge scl);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, protocol state %s", cycle_count,
                 i_eeprom_top.i_protocol.state.name());
        $display("Errors: %0d in %0d checks", errors, checks);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        rst_n  = 1'b0;
        sck    = 1'b1;
        sda_m  = 1'b1;
        errors = 0;
        checks = 0;
        n_used = 0;
        seed   = 32'ha10f;
        for (int a = 0; a < mem_depth; a++)
        begin
            ref_mem[a] = '0;
        end

        add_entry(op_read, dev_type, 3'd0, 8'h00, 8'h00, 1'b1, "reset_read_p0");
        add_entry(op_read, dev_type, 3'd3, 8'h5a, 8'h00, 1'b1, "reset_read_p3");
        add_entry(op_read, dev_type, 3'd7, 8'hff, 8'h00, 1'b1, "reset_read_p7");
        add_entry(op_write, dev_type, 3'd2, 8'h10, 8'h3c, 1'b1, "write_p2");
        add_entry(op_read, dev_type, 3'd2, 8'h10, 8'h00, 1'b1, "readback_p2");
        add_entry(op_write, dev_type, 3'd1, 8'h40, 8'ha5, 1'b1, "page_write_p1");
        add_entry(op_write, dev_type, 3'd5, 8'h40, 8'h5a, 1'b1, "page_write_p5");
        add_entry(op_read, dev_type, 3'd1, 8'h40, 8'h00, 1'b1, "page_read_p1");
        add_entry(op_read, dev_type, 3'd5, 8'h40, 8'h00, 1'b1, "page_read_p5");
        add_entry(op_write, 4'b1011, 3'd4, 8'h22, 8'h77, 1'b0, "wrong_dev");
        add_entry(op_read, dev_type, 3'd4, 8'h22, 8'h00, 1'b1, "wrong_dev_read");
        add_entry(op_abort, dev_type, 3'd6, 8'h33, 8'h99, 1'b1, "stop_abort");
        add_entry(op_read, dev_type, 3'd6, 8'h33, 8'h00, 1'b1, "abort_read");
        add_entry(op_write, dev_type, 3'd6, 8'h34, 8'h42, 1'b1, "after_abort_write");
        add_entry(op_read, dev_type, 3'd6, 8'h34, 8'h00, 1'b1, "after_abort_read");
        for (int k = 0; k < 12; k++)
        begin
            rnd_word    = $random(seed);
            rnd_page[k] = rnd_word[2:0];
            rnd_word    = $random(seed);
            rnd_addr[k] = rnd_word[7:0];
            rnd_word    = $random(seed);
            rnd_data[k] = rnd_word[7:0];
            add_entry(op_write, dev_type, rnd_page[k], rnd_addr[k], rnd_data[k], 1'b1,
                      $sformatf("rand_wr_%0d", k));
        end
        // Stride 5 visits all twelve locations in a new order
        for (int k = 0; k < 12; k++)
        begin
            add_entry(op_read, dev_type, rnd_page[(k * 5) % 12], rnd_addr[(k * 5) % 12],
                      8'h00, 1'b1, $sformatf("rand_rd_%0d", (k * 5) % 12));
        end

        wait_cycles(reset_cycles);
        rst_n = 1'b1;
        wait_cycles(8);

        for (int i = 0; i < n_used; i++)
        begin
            run_entry(i);
        end

        $display("Errors: %0d in %0d checks", errors, checks);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire
